/* rsAlu.f */
+incdir+tb
verilog/rsAluPkg.sv
verilog/rsPayloadTable.sv
verilog/rsOperandTable.sv
verilog/rsIssueSelect.sv
verilog/rsAlu.sv
tb/rsAluTb.sv

/* Makefile */
# Verilator build and run for the rsAlu reservation station

VERILATOR ?= verilator
TOP       ?= rsAluTb
RTL_TOP   ?= rsAlu
FILELIST  ?= rsAlu.f
OBJDIR    ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS  ?= verilog/rsAluPkg.sv verilog/rsPayloadTable.sv verilog/rsOperandTable.sv \
             verilog/rsIssueSelect.sv verilog/rsAlu.sv
TB_SRCS   ?= tb/rsAluTb.sv tb/rsAluTests.svh

PASS_MSG  := Finished with no errors

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)" || exit 1

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJDIR)

/* tb/rsAluTests.svh */
`ifndef RS_ALU_TESTS_SVH
`define RS_ALU_TESTS_SVH

task automatic resetIdle();
    currentTest = "resetIdle";
    waitCycles(1);
    checkValue("issue", '0, CheckWidth'(issue));
    repeat (5) begin
        checkValue("full", '0, CheckWidth'(full));
        checkValue("issueValid", '0, CheckWidth'(issueValid));
        waitCycles(1);
    end
endtask

task automatic readyDispatch();
    rsAluPkg::rsPayload_t pl;
    rsAluPkg::data_t      a;
    rsAluPkg::data_t      b;
    currentTest = "readyDispatch";
    pl = randomPayload();
    a  = $random(seed);
    b  = $random(seed);
    expectIssue(modelAlloc(), {pl, a, b});
    dispatch(pl, readyOp(a), readyOp(b));
    waitCycles(2);      // issue one edge after dispatch
    expectDrained();
endtask

task automatic wakeEachSource();
    rsAluPkg::rsPayload_t pl;
    rsAluPkg::data_t      a;
    rsAluPkg::data_t      wd;
    rsAluPkg::tag_t       tag;
    int                   slot;
    for (int src = 0; src < 4; src++) begin
        currentTest = $sformatf("wakeSource%0d", src);
        pl   = randomPayload();
        a    = $random(seed);
        wd   = $random(seed);
        tag  = rsAluPkg::tag_t'(8'h10 + src);
        slot = modelAlloc();
        if (src % 2 == 1) begin     // odd sources wake operand 1
            dispatch(pl, waitOp(tag), readyOp(a));
        end else begin
            dispatch(pl, readyOp(a), waitOp(tag));
        end
        @(posedge clk);
        driveBus(src, 1'b0, tag, $random(seed));
        endCycle();
        waitCycles(2);
        checkValue("issueValid", '0, CheckWidth'(issueValid));
        @(posedge clk);
        driveBus(src, 1'b1, tag ^ 8'h01, $random(seed));
        endCycle();
        waitCycles(2);
        checkValue("issueValid", '0, CheckWidth'(issueValid));
        if (src % 2 == 1) begin
            expectIssue(slot, {pl, wd, a});
        end else begin
            expectIssue(slot, {pl, a, wd});
        end
        @(posedge clk);
        driveBus(src, 1'b1, tag, wd);
        endCycle();
        waitCycles(2);
        expectDrained();
    end
endtask

task automatic bypassDispatch();
    rsAluPkg::rsPayload_t pl;
    rsAluPkg::data_t      a;
    rsAluPkg::data_t      x;
    rsAluPkg::data_t      y;
    currentTest = "bypassLoad";
    pl = randomPayload();
    a  = $random(seed);
    x  = $random(seed);
    expectIssue(modelAlloc(), {pl, x, a});
    @(posedge clk);
    driveDispatch(pl, waitOp(8'h40), readyOp(a));
    driveBus(3, 1'b1, 8'h40, x);
    endCycle();
    waitCycles(2);
    expectDrained();
    currentTest = "bypassAluWins";
    pl = randomPayload();
    x  = $random(seed);
    y  = $random(seed);
    expectIssue(modelAlloc(), {pl, x, x});
    @(posedge clk);
    driveDispatch(pl, waitOp(8'h41), waitOp(8'h41));
    driveBus(1, 1'b1, 8'h41, y);
    driveBus(0, 1'b1, 8'h41, x);
    endCycle();
    waitCycles(2);
    expectDrained();
endtask

task automatic fillStation();
    rsAluPkg::issuePacket_t pkts [NumEntries];
    rsAluPkg::rsPayload_t   pl;
    rsAluPkg::data_t        a;
    rsAluPkg::data_t        wd;
    int                     slot;
    currentTest = "fillStation";
    wd = $random(seed);
    for (int i = 0; i < NumEntries; i++) begin
        pl   = randomPayload();
        a    = $random(seed);
        slot = modelAlloc();
        pkts[slot] = {pl, a, wd};
        dispatch(pl, readyOp(a), waitOp(8'h77));
    end
    waitCycles(1);
    checkValue("full", CheckWidth'(&modelBusy), CheckWidth'(full));
    dispatch(randomPayload(), readyOp($random(seed)), readyOp($random(seed)));
    waitCycles(2);
    checkValue("issueValid", '0, CheckWidth'(issueValid));
    for (int i = 0; i < NumEntries; i++) begin
        expectIssue(i, pkts[i]);        // ascending slot order
    end
    @(posedge clk);
    driveBus(0, 1'b1, 8'h77, wd);
    endCycle();
    waitCycles(1);
    checkValue("full", CheckWidth'(&modelBusy), CheckWidth'(full));
    waitCycles(1);
    checkValue("full", CheckWidth'(&modelBusy), CheckWidth'(full));
    checkValue("pending", CheckWidth'(NumEntries - 1), CheckWidth'(expectedQ.size()));
    waitCycles(NumEntries - 1);
    expectDrained();
    waitCycles(3);
    checkValue("issueValid", '0, CheckWidth'(issueValid));
endtask

`endif

/* tb/rsAluTb.sv */
`timescale 1ns/10ps
`default_nettype none

module rsAluTb;

    localparam int NumEntries = 8;
    localparam int MaxCycles  = 400;    // tests need about 120 cycles
    localparam int CheckWidth = $bits(rsAluPkg::issuePacket_t);

    logic                   clk;
    logic                   reset;
    logic                   start;
    rsAluPkg::rsPayload_t   payload;
    rsAluPkg::srcOperand_t  src1;
    rsAluPkg::srcOperand_t  src2;
    rsAluPkg::resultBus_t   aluResult;
    rsAluPkg::resultBus_t   mulResult;
    rsAluPkg::resultBus_t   divResult;
    rsAluPkg::resultBus_t   loadResult;
    logic                   full;
    logic                   issueValid;
    rsAluPkg::issuePacket_t issue;

    rsAluPkg::issuePacket_t expectedQ [$];      // packets in issue order
    int                     expectedSlotQ [$];
    logic [NumEntries-1:0]  modelBusy;
    string                  currentTest;
    int                     cycleCount;
    int                     seed;

    rsAlu #(.NumEntries(NumEntries)) u_dut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .payload    (payload),
        .src1       (src1),
        .src2       (src2),
        .aluResult  (aluResult),
        .mulResult  (mulResult),
        .divResult  (divResult),
        .loadResult (loadResult),
        .full       (full),
        .issueValid (issueValid),
        .issue      (issue)
    );

    always #5 clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string what, input logic [CheckWidth-1:0] expected,
                              input logic [CheckWidth-1:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] %s %s: expected %h, actual %h",
                              currentTest, what, expected, actual));
        end
    endtask

    // lowest free slot, -1 when full
    function automatic int modelAlloc();
        for (int i = 0; i < NumEntries; i++) begin
            if (!modelBusy[i]) begin
                modelBusy[i] = 1'b1;
                return i;
            end
        end
        return -1;
    endfunction

    task automatic expectIssue(input int slot, input rsAluPkg::issuePacket_t pkt);
        expectedQ.push_back(pkt);
        expectedSlotQ.push_back(slot);
    endtask

    task automatic expectDrained();
        if (expectedQ.size() != 0) begin
            failRun($sformatf("%s: an expected issue pulse never arrived", currentTest));
        end
    endtask

    function automatic rsAluPkg::rsPayload_t randomPayload();
        rsAluPkg::rsPayload_t pl;
        pl.pc      = $random(seed);
        pl.rd      = rsAluPkg::tag_t'($random(seed));
        pl.aluOp   = rsAluPkg::aluOp_t'($random(seed));
        pl.aluSrc1 = 2'($random(seed));
        pl.aluSrc2 = 2'($random(seed));
        pl.jump    = 1'($random(seed));
        pl.branch  = 1'($random(seed));
        pl.funct3  = rsAluPkg::funct3_t'($random(seed));
        pl.imm     = $random(seed);
        return pl;
    endfunction

    function automatic rsAluPkg::srcOperand_t readyOp(input rsAluPkg::data_t data);
        return {rsAluPkg::tag_t'(0), data, 1'b1};
    endfunction

    // data is junk and must not reach the packet
    function automatic rsAluPkg::srcOperand_t waitOp(input rsAluPkg::tag_t tag);
        return {tag, rsAluPkg::data_t'($random(seed)), 1'b0};
    endfunction

    task automatic driveDispatch(input rsAluPkg::rsPayload_t pl,
                                 input rsAluPkg::srcOperand_t s1,
                                 input rsAluPkg::srcOperand_t s2);
        start   <= 1'b1;
        payload <= pl;
        src1    <= s1;
        src2    <= s2;
    endtask

    // which: 0 alu, 1 mul, 2 div, 3 load
    task automatic driveBus(input int which, input logic valid, input rsAluPkg::tag_t tag,
                            input rsAluPkg::data_t data);
        case (which)
            0:       aluResult  <= {valid, tag, data};
            1:       mulResult  <= {valid, tag, data};
            2:       divResult  <= {valid, tag, data};
            default: loadResult <= {valid, tag, data};
        endcase
    endtask

    task automatic clearBuses();
        aluResult  <= '0;
        mulResult  <= '0;
        divResult  <= '0;
        loadResult <= '0;
    endtask

    // next edge samples the driven values, then inputs go idle
    task automatic endCycle();
        @(posedge clk);
        start <= 1'b0;
        clearBuses();
    endtask

    task automatic dispatch(input rsAluPkg::rsPayload_t pl, input rsAluPkg::srcOperand_t s1,
                            input rsAluPkg::srcOperand_t s2);
        @(posedge clk);
        driveDispatch(pl, s1, s2);
        endCycle();
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(negedge clk);
        #1;     // after the issue monitor
    endtask

    always @(negedge clk) begin
        if (!reset && issueValid) begin
            if (expectedQ.size() == 0) begin
                failRun($sformatf("%s: issue pulse while no packet was expected", currentTest));
            end else begin
                checkValue("issue", CheckWidth'(expectedQ[0]), CheckWidth'(issue));
                modelBusy[expectedSlotQ[0]] = 1'b0;
                void'(expectedQ.pop_front());
                void'(expectedSlotQ.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            failRun($sformatf("timeout, run did not end within %0d cycles", MaxCycles));
        end
    end

    `include "rsAluTests.svh"

    initial begin
        seed        = 32'he063_6abf;
        clk         = 1'b0;
        cycleCount  = 0;
        modelBusy   = '0;
        currentTest = "reset";
        reset   <= 1'b1;
        start   <= 1'b0;
        payload <= '0;
        src1    <= '0;
        src2    <= '0;
        clearBuses();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        resetIdle();
        readyDispatch();
        wakeEachSource();
        bypassDispatch();
        fillStation();
        waitCycles(3);
        if (expectedQ.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            failRun("packets still pending at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* verilog/rsAlu.sv */
`timescale 1ns/10ps
`default_nettype none

module rsAlu #(
    parameter int NumEntries = 8
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         start,
    input  wire rsAluPkg::rsPayload_t   payload,
    input  wire rsAluPkg::srcOperand_t  src1,
    input  wire rsAluPkg::srcOperand_t  src2,
    input  wire rsAluPkg::resultBus_t   aluResult,
    input  wire rsAluPkg::resultBus_t   mulResult,
    input  wire rsAluPkg::resultBus_t   divResult,
    input  wire rsAluPkg::resultBus_t   loadResult,
    output logic                        full,
    output logic                        issueValid,
    output rsAluPkg::issuePacket_t      issue
);

    localparam int IdxWidth = $clog2(NumEntries);

    logic                  allocWrite;
    logic [IdxWidth-1:0]   allocIdx;
    logic [NumEntries-1:0] busy;
    logic [NumEntries-1:0] operandReady;
    logic [NumEntries-1:0] issueGrant;

    rsAluPkg::rsPayload_t entryPayload [NumEntries];
    rsAluPkg::data_t      operand1Data [NumEntries];
    rsAluPkg::data_t      operand2Data [NumEntries];

    rsPayloadTable #(.NumEntries(NumEntries)) u_payloadTable (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .payload      (payload),
        .issueGrant   (issueGrant),
        .full         (full),
        .allocWrite   (allocWrite),
        .allocIdx     (allocIdx),
        .busy         (busy),
        .entryPayload (entryPayload)
    );

    rsOperandTable #(.NumEntries(NumEntries)) u_operandTable (
        .clk          (clk),
        .reset        (reset),
        .allocWrite   (allocWrite),
        .allocIdx     (allocIdx),
        .src1         (src1),
        .src2         (src2),
        .aluResult    (aluResult),
        .mulResult    (mulResult),
        .divResult    (divResult),
        .loadResult   (loadResult),
        .operandReady (operandReady),
        .operand1Data (operand1Data),
        .operand2Data (operand2Data)
    );

    rsIssueSelect #(.NumEntries(NumEntries)) u_issueSelect (
        .clk          (clk),
        .reset        (reset),
        .busy         (busy),
        .operandReady (operandReady),
        .entryPayload (entryPayload),
        .operand1Data (operand1Data),
        .operand2Data (operand2Data),
        .issueGrant   (issueGrant),
        .issueValid   (issueValid),
        .issue        (issue)
    );

endmodule

`default_nettype wire

/* verilog/rsIssueSelect.sv */
`timescale 1ns/10ps
`default_nettype none

module rsIssueSelect #(
    parameter  int NumEntries = 8,
    localparam int IdxWidth   = $clog2(NumEntries)
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire [NumEntries-1:0]        busy,
    input  wire [NumEntries-1:0]        operandReady,
    input  wire rsAluPkg::rsPayload_t   entryPayload [NumEntries],
    input  wire rsAluPkg::data_t        operand1Data [NumEntries],
    input  wire rsAluPkg::data_t        operand2Data [NumEntries],
    output logic [NumEntries-1:0]       issueGrant,
    output logic                        issueValid,
    output rsAluPkg::issuePacket_t      issue
);

    logic [NumEntries-1:0] readySet;
    logic [IdxWidth-1:0]   grantIdx;
    logic                  anyReady;

    // stale valid bits of freed slots are masked by busy
    assign readySet = busy & operandReady;
    assign anyReady = |readySet;

    always_comb begin
        grantIdx = '0;
        for (int i = NumEntries - 1; i >= 0; i--) begin
            if (readySet[i]) begin
                grantIdx = IdxWidth'(i);
            end
        end
    end

    assign issueGrant = anyReady ? (NumEntries'(1) << grantIdx) : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issueValid <= 1'b0;
            issue      <= '0;
        end else begin
            issueValid <= anyReady;     // one pulse per grant
            if (anyReady) begin
                issue.payload  <= entryPayload[grantIdx];
                issue.operand1 <= operand1Data[grantIdx];
                issue.operand2 <= operand2Data[grantIdx];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rsOperandTable.sv */
`timescale 1ns/10ps
`default_nettype none

module rsOperandTable #(
    parameter  int NumEntries = 8,
    localparam int IdxWidth   = $clog2(NumEntries)
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         allocWrite,
    input  wire [IdxWidth-1:0]          allocIdx,
    input  wire rsAluPkg::srcOperand_t  src1,
    input  wire rsAluPkg::srcOperand_t  src2,
    input  wire rsAluPkg::resultBus_t   aluResult,
    input  wire rsAluPkg::resultBus_t   mulResult,
    input  wire rsAluPkg::resultBus_t   divResult,
    input  wire rsAluPkg::resultBus_t   loadResult,
    output logic [NumEntries-1:0]       operandReady,
    output rsAluPkg::data_t             operand1Data [NumEntries],
    output rsAluPkg::data_t             operand2Data [NumEntries]
);

    rsAluPkg::resultBus_t [rsAluPkg::NumBuses-1:0] bus;

    rsAluPkg::srcOperand_t src    [2];
    rsAluPkg::tag_t        opTag  [2][NumEntries];
    rsAluPkg::data_t       opData [2][NumEntries];
    logic [NumEntries-1:0] opValid [2];

    // index 0 has the highest priority
    assign bus = {loadResult, divResult, mulResult, aluResult};

    assign src[0] = src1;
    assign src[1] = src2;

    // matching valid broadcast, alu first
    function automatic rsAluPkg::resultBus_t pickBus(
        input rsAluPkg::resultBus_t [rsAluPkg::NumBuses-1:0] buses,
        input rsAluPkg::tag_t                                tag
    );
        rsAluPkg::resultBus_t hit;
        hit = '0;
        for (int b = rsAluPkg::NumBuses - 1; b >= 0; b--) begin
            if (buses[b].valid && buses[b].tag == tag) begin
                hit = buses[b];
            end
        end
        return hit;
    endfunction

    for (genvar op = 0; op < 2; op++) begin : gOperand
        rsAluPkg::resultBus_t capture;
        rsAluPkg::resultBus_t wake [NumEntries];

        always_comb begin
            capture = pickBus(bus, src[op].tag);
            for (int i = 0; i < NumEntries; i++) begin
                wake[i] = pickBus(bus, opTag[op][i]);
            end
        end

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                opValid[op] <= '0;
            end else begin
                for (int i = 0; i < NumEntries; i++) begin
                    if (allocWrite && allocIdx == IdxWidth'(i)) begin
                        opValid[op][i] <= src[op].valid || capture.valid;   // bypass
                    end else if (!opValid[op][i] && wake[i].valid) begin
                        opValid[op][i] <= 1'b1;
                    end
                end
            end
        end

        always_ff @(posedge clk) begin
            for (int i = 0; i < NumEntries; i++) begin
                if (allocWrite && allocIdx == IdxWidth'(i)) begin
                    opTag[op][i]  <= src[op].tag;
                    opData[op][i] <= src[op].valid ? src[op].data : capture.data;
                end else if (!opValid[op][i] && wake[i].valid) begin
                    opData[op][i] <= wake[i].data;      // wakeup
                end
            end
        end
    end

    assign operandReady = opValid[0] & opValid[1];

    assign operand1Data = opData[0];
    assign operand2Data = opData[1];

endmodule

`default_nettype wire

/* verilog/rsPayloadTable.sv */
`timescale 1ns/10ps
`default_nettype none

module rsPayloadTable #(
    parameter  int NumEntries = 8,
    localparam int IdxWidth   = $clog2(NumEntries)
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         start,
    input  wire rsAluPkg::rsPayload_t   payload,
    input  wire [NumEntries-1:0]        issueGrant,
    output logic                        full,
    output logic                        allocWrite,
    output logic [IdxWidth-1:0]         allocIdx,
    output logic [NumEntries-1:0]       busy,
    output rsAluPkg::rsPayload_t        entryPayload [NumEntries]
);

    logic [NumEntries-1:0] allocMask;

    assign full       = &busy;
    assign allocWrite = start && !full;     // dispatch while full is dropped

    // lowest free slot wins
    always_comb begin
        allocIdx = '0;
        for (int i = NumEntries - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                allocIdx = IdxWidth'(i);
            end
        end
    end

    always_comb begin
        allocMask = '0;
        if (allocWrite) begin
            allocMask = NumEntries'(1) << allocIdx;
        end
    end

    // alloc only hits free slots, grant only busy ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~issueGrant) | allocMask;
        end
    end

    always_ff @(posedge clk) begin
        if (allocWrite) begin
            entryPayload[allocIdx] <= payload;
        end
    end

endmodule

`default_nettype wire

/* verilog/rsAluPkg.sv */
`default_nettype none

package rsAluPkg;

    localparam int TagWidth  = 8;
    localparam int DataWidth = 32;
    localparam int NumBuses  = 4;   // alu, mul, div, load

    typedef logic [TagWidth-1:0]  tag_t;
    typedef logic [DataWidth-1:0] data_t;
    typedef logic [3:0]           aluOp_t;
    typedef logic [2:0]           funct3_t;

    // one result broadcast
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } resultBus_t;

    // operand as presented at dispatch
    typedef struct packed {
        tag_t  tag;
        data_t data;
        logic  valid;   // data already present
    } srcOperand_t;

    typedef struct packed {
        data_t      pc;
        tag_t       rd;
        aluOp_t     aluOp;
        logic [1:0] aluSrc1;    // rs1 / pc / zero
        logic [1:0] aluSrc2;    // rs2 / imm / 4
        logic       jump;
        logic       branch;
        funct3_t    funct3;
        data_t      imm;
    } rsPayload_t;

    typedef struct packed {
        rsPayload_t payload;
        data_t      operand1;
        data_t      operand2;
    } issuePacket_t;

endpackage

`default_nettype wire
